// ==== filelist.f ====
source/sdram_timing_pkg.sv
source/sdram_cmd_pkg.sv
source/sdram_arb.sv
source/sdram_cmd_fifo.sv
source/sdram_io.sv
source/sdram_ctrl.sv
verif/sdram_device_model.sv
verif/sdram_checker.sv
verif/tb_sdram_ctrl.sv

// ==== verif/tb_sdram_ctrl.sv ====
`default_nettype none

module tb_sdram_ctrl import sdram_timing_pkg::*, sdram_cmd_pkg::*;;

localparam int N_PER_SRC = 60;
localparam int WATCHDOG  = T_INIT + 200 * N_PER_SRC * N_SRC;

logic                     CLK = 1'b0;
logic                     RESET_IN;
logic [N_SRC-1:0]         src_req;
dram_access_t [N_SRC-1:0] src_acs;
logic [N_SRC-1:0]         src_ack;
logic                     init_done;
logic                     rd_valid;
data_t                    rd_data;
tag_t                     rd_tag;
wire  [15:0]              dram_dq;
logic [12:0]              dram_addr;
bank_t                    dram_ba;
logic [1:0]               dram_dqm;
wire                      dram_clk;
logic                     dram_cke;
logic                     dram_cs_n;
logic                     dram_ras_n;
logic                     dram_cas_n;
logic                     dram_we_n;

integer seed = 21;
int     sent [N_SRC];
logic   traffic_on = 1'b0;
int     tb_errors = 0;
int     n_tests = 0;

always #5 CLK = ~CLK;

sdram_ctrl sdram_ctrl_inst (.*);

sdram_device_model dev (
    .dram_clk (dram_clk),
    .cs_n     (dram_cs_n),
    .ras_n    (dram_ras_n),
    .cas_n    (dram_cas_n),
    .we_n     (dram_we_n),
    .addr     (dram_addr),
    .ba       (dram_ba),
    .dq       (dram_dq)
);

sdram_checker chk (.*);

// small address pool, 64 words, so reads hit earlier writes
function automatic dram_access_t random_access();
    logic [31:0]  r;
    dram_access_t a;

    r       = $random(seed);
    a.write = r[6];
    a.bank  = r[1:0];
    a.row   = row_t'(r[3:2]);
    a.col   = col_t'(r[5:4]);
    a.data  = r[31:16];
    return a;
endfunction

task automatic report_test(input string name, input int err_before);
    n_tests++;
    $display("test %s: %0d checks so far, %0d new errors", name, chk.checks,
             chk.errors + tb_errors - err_before);
endtask

// next access as soon as the previous one is acknowledged
always @(negedge CLK) begin
    if (traffic_on) begin
        for (int s = 0; s < N_SRC; s++) begin
            if (src_req[s] && src_ack[s]) begin
                sent[s]++;
                if (sent[s] < N_PER_SRC)
                    src_acs[s] = random_access();
                else
                    src_req[s] = 1'b0;
            end
        end
    end
end

initial begin
    repeat (WATCHDOG) @(posedge CLK);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
    $display("Simulation failed");
    $finish;
end

initial begin
    int err0;
    int n;

    RESET_IN = 1'b1;
    src_req  = '0;
    src_acs  = '0;
    sent     = '{default: 0};
    chk.test_name = "init";
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RESET_IN = 1'b0;

    err0 = 0;
    n = 0;
    while (!init_done && n < T_INIT + 100) begin
        @(posedge CLK);
        n++;
    end
    if (!init_done) begin
        tb_errors++;
        $display("init_done did not rise within %0d cycles", T_INIT + 100);
    end
    report_test("init", err0);

    err0 = chk.errors + tb_errors;
    chk.test_name = "random_traffic";
    @(negedge CLK);
    for (int s = 0; s < N_SRC; s++)
        src_acs[s] = random_access();
    src_req    = '1;
    traffic_on = 1'b1;
    while (src_req != '0)
        @(posedge CLK);
    report_test("random_traffic", err0);

    err0 = chk.errors + tb_errors;
    chk.test_name = "drain";
    n = 0;
    while (chk.outstanding != 0 && n < 200) begin
        @(posedge CLK);
        n++;
    end
    if (chk.outstanding != 0) begin
        tb_errors++;
        $display("%0d accesses never finished", chk.outstanding);
    end
    report_test("drain", err0);

    // idle long enough to see the refresh interval checked without traffic
    err0 = chk.errors + tb_errors;
    chk.test_name = "idle_refresh";
    repeat (T_REF + 2 * T_RC + 20) @(posedge CLK);
    report_test("idle_refresh", err0);

    $display("%0d tests, %0d checks, %0d errors", n_tests, chk.checks,
             chk.errors + tb_errors);
    if (chk.errors + tb_errors == 0)
        $display("Simulation passed");
    else
        $display("Simulation failed");
    $finish;
end

endmodule

`default_nettype wire

// ==== verif/sdram_checker.sv ====
`default_nettype none

module sdram_checker import sdram_timing_pkg::*, sdram_cmd_pkg::*; (
    input  wire                      CLK,
    input  wire                      RESET_IN,
    input  logic [N_SRC-1:0]         src_req,
    input  dram_access_t [N_SRC-1:0] src_acs,
    input  logic [N_SRC-1:0]         src_ack,
    input  logic                     init_done,
    input  logic                     rd_valid,
    input  data_t                    rd_data,
    input  tag_t                     rd_tag,
    input  logic [12:0]              dram_addr,
    input  logic [1:0]               dram_dqm,
    input  logic                     dram_cke,
    input  logic                     dram_cs_n,
    input  logic                     dram_ras_n,
    input  logic                     dram_cas_n,
    input  logic                     dram_we_n
);

localparam logic [12:0] MODE_EXP = 13'(CAS_CYCLES << 4);   // cas in a6:a4, burst length 1
localparam int          REF_MAX  = T_REF + 2 * T_RC;

int errors = 0;
int checks = 0;
int outstanding = 0;                        // accepted but not finished accesses

string       test_name = "init";            // current test, named by the testbench
int          cyc = 0;
int          init_step = 0;
logic        init_seen = 1'b0;
int          last_act = -1000;
int          last_ref = 0;
int          rd_cyc_q[$];
data_t       exp_q [N_SRC][$];
int          waits [N_SRC];
data_t       mem_model [logic [23:0]];
dram_access_t [N_SRC-1:0] acs_q;            // access as the arbiter sampled it

task automatic fail_value(input string name, input int unsigned exp, input int unsigned act);
    errors++;
    $display("FAILED %s %s: expected %0h actual %0h", test_name, name, exp, act);
endtask

task automatic fail_text(input string what);
    errors++;
    $display("ERROR at cycle %0d: %s", cyc, what);
endtask

function automatic logic [23:0] addr_key(input dram_access_t a);
    return {a.bank, a.row, a.col};
endfunction

always @(posedge CLK) begin
    logic [3:0]   pc;
    dram_access_t a;
    data_t        exp;

    pc = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n};
    if (!RESET_IN) begin
        cyc++;
        if (dram_cke !== 1'b1)
            fail_text("CKE is low, the device would leave normal operation");

        // init order: precharge all, refresh, refresh, mode register
        if (!init_done && pc != PIN_NOP) begin
            checks++;
            case (init_step)
                0: if (pc != PIN_PRE || !dram_addr[10])
                    fail_text("expected PRECHARGE ALL first during init");
                1, 2: if (pc != PIN_REF)
                    fail_text("expected AUTO REFRESH during init");
                3: begin
                    if (pc != PIN_MRS)
                        fail_text("expected LOAD MODE during init");
                    else if (dram_addr != MODE_EXP)
                        fail_value("mode_register", MODE_EXP, dram_addr);
                end
                default: fail_text("command on the pins after init sequence, before init_done");
            endcase
            init_step++;
        end
        if (init_done && !init_seen) begin
            init_seen = 1'b1;
            last_ref  = cyc;
            checks++;
            if (init_step != 4)
                fail_value("init_sequence_length", 4, init_step);
        end

        // device timing
        if (pc == PIN_RD || pc == PIN_WR) begin
            checks++;
            if (cyc - last_act < T_RCD)
                fail_value("t_rcd", T_RCD, cyc - last_act);
            if (dram_dqm !== 2'b00)
                fail_value("dqm", 0, dram_dqm);     // a masked word is lost
            if (pc == PIN_RD)
                rd_cyc_q.push_back(cyc);
            else
                outstanding--;
        end
        if (pc == PIN_ACT || pc == PIN_REF) begin
            checks++;
            if (cyc - last_act < T_RC)
                fail_value("t_rc", T_RC, cyc - last_act);
            if (pc == PIN_ACT)
                last_act = cyc;
            else
                last_ref = cyc;
        end
        if (init_seen && cyc - last_ref > REF_MAX) begin
            fail_text("auto refresh missing for too long");
            last_ref = cyc;
        end

        // acceptance, expected values taken at ack time
        for (int s = 0; s < N_SRC; s++) begin
            if (src_ack[s]) begin
                a = acs_q[s];
                outstanding++;
                checks++;
                if (outstanding > CMD_FIFO_DEPTH + 1)
                    fail_value("in_flight", CMD_FIFO_DEPTH + 1, outstanding);
                if (a.write)
                    mem_model[addr_key(a)] = a.data;
                else if (mem_model.exists(addr_key(a)))
                    exp_q[s].push_back(mem_model[addr_key(a)]);
                else
                    exp_q[s].push_back('0);
                waits[s] = 0;
                for (int o = 0; o < N_SRC; o++) begin
                    if (o != s && src_req[o] && !src_ack[o]) begin
                        waits[o]++;
                        if (waits[o] > 2)
                            fail_text($sformatf("source %0d starved by round robin", o));
                    end
                end
            end
        end

        // read return
        if (rd_valid) begin
            outstanding--;
            checks += 2;
            if (rd_cyc_q.size() == 0)
                fail_text("rd_valid without a READ on the pins");
            else if (cyc - rd_cyc_q[0] != CAS_CYCLES + 1)
                fail_value("read_latency", CAS_CYCLES + 1, cyc - rd_cyc_q.pop_front());
            else
                void'(rd_cyc_q.pop_front());
            if (exp_q[rd_tag].size() == 0) begin
                fail_text($sformatf("read data returned for tag %0d with no pending read",
                                    rd_tag));
            end else begin
                exp = exp_q[rd_tag].pop_front();
                if (rd_data !== exp)
                    fail_value($sformatf("read_data tag %0d", rd_tag), exp, rd_data);
            end
        end
    end
    acs_q <= src_acs;
end

endmodule

`default_nettype wire

// ==== verif/sdram_device_model.sv ====
`default_nettype none

module sdram_device_model import sdram_timing_pkg::*; (
    input  wire        dram_clk,
    input  wire        cs_n,
    input  wire        ras_n,
    input  wire        cas_n,
    input  wire        we_n,
    input  wire [12:0] addr,
    input  wire [1:0]  ba,
    inout  wire [15:0] dq
);

logic [12:0] open_row [4];
logic [15:0] mem [logic [23:0]];            // sparse, keyed by {bank, row, col}

logic [CAS_CYCLES-1:0] rd_v = '0;
logic [15:0]           rd_d [CAS_CYCLES];

// read data stays on the bus for one clock, cas latency after the READ edge
assign dq = rd_v[CAS_CYCLES-1] ? rd_d[CAS_CYCLES-1] : 'z;

function automatic logic [15:0] read_word(input logic [23:0] key);
    if (mem.exists(key))
        return mem[key];
    return 16'h0000;                        // unwritten words read as zero
endfunction

always @(posedge dram_clk) begin
    logic [23:0] key;

    key  = {ba, open_row[ba], addr[8:0]};
    rd_v <= {rd_v[CAS_CYCLES-2:0], 1'b0};
    for (int i = 1; i < CAS_CYCLES; i++)
        rd_d[i] <= rd_d[i-1];

    case ({cs_n, ras_n, cas_n, we_n})
        4'b0011: open_row[ba] <= addr;      // activate
        4'b0101: begin                      // read
            rd_v[0] <= 1'b1;
            rd_d[0] <= read_word(key);
        end
        4'b0100: mem[key] = dq;             // write
        default: ;
    endcase
end

endmodule

`default_nettype wire

// ==== source/sdram_ctrl.sv ====
`default_nettype none

module sdram_ctrl import sdram_cmd_pkg::*; (
    input  wire                       CLK,
    input  wire                       RESET_IN,

    // access sources
    input  logic [N_SRC-1:0]          src_req,
    input  dram_access_t [N_SRC-1:0]  src_acs,
    output logic [N_SRC-1:0]          src_ack,

    output logic                      init_done,

    // read return, no back-pressure
    output logic                      rd_valid,
    output data_t                     rd_data,
    output tag_t                      rd_tag,

    // device pins
    inout  wire   [15:0]              dram_dq,
    output logic  [12:0]              dram_addr,
    output bank_t                     dram_ba,
    output logic  [1:0]               dram_dqm,
    output wire                       dram_clk,
    output logic                      dram_cke,
    output logic                      dram_cs_n,
    output logic                      dram_ras_n,
    output logic                      dram_cas_n,
    output logic                      dram_we_n
);

logic cmd_push;
cmd_t cmd_data;
logic credit_ret;
logic cmd_valid;
cmd_t head_cmd;
logic cmd_pop;

sdram_arb arb (
    .CLK        (CLK),
    .RESET_IN   (RESET_IN),
    .init_done  (init_done),
    .src_req    (src_req),
    .src_acs    (src_acs),
    .src_ack    (src_ack),
    .credit_ret (credit_ret),
    .cmd_push   (cmd_push),
    .cmd_data   (cmd_data)
);

sdram_cmd_fifo cmd_fifo (
    .CLK        (CLK),
    .RESET_IN   (RESET_IN),
    .cmd_push   (cmd_push),
    .cmd_data   (cmd_data),
    .cmd_pop    (cmd_pop),
    .cmd_valid  (cmd_valid),
    .head_cmd   (head_cmd),
    .credit_ret (credit_ret)
);

sdram_io io (
    .CLK        (CLK),
    .RESET_IN   (RESET_IN),
    .cmd_valid  (cmd_valid),
    .head_cmd   (head_cmd),
    .cmd_pop    (cmd_pop),
    .init_done  (init_done),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .rd_tag     (rd_tag),
    .dram_dq    (dram_dq),
    .dram_addr  (dram_addr),
    .dram_ba    (dram_ba),
    .dram_dqm   (dram_dqm),
    .dram_clk   (dram_clk),
    .dram_cke   (dram_cke),
    .dram_cs_n  (dram_cs_n),
    .dram_ras_n (dram_ras_n),
    .dram_cas_n (dram_cas_n),
    .dram_we_n  (dram_we_n)
);

endmodule

`default_nettype wire

// ==== source/sdram_io.sv ====
`default_nettype none

module sdram_io import sdram_timing_pkg::*, sdram_cmd_pkg::*; (
    input  wire          CLK,
    input  wire          RESET_IN,

    // command buffer
    input  logic         cmd_valid,
    input  cmd_t         head_cmd,
    output logic         cmd_pop,

    output logic         init_done,

    // read return
    output logic         rd_valid,
    output data_t        rd_data,
    output tag_t         rd_tag,

    // device pins
    inout  wire   [15:0] dram_dq,
    output logic  [12:0] dram_addr,
    output bank_t        dram_ba,
    output logic  [1:0]  dram_dqm,
    output wire          dram_clk,
    output logic         dram_cke,
    output logic         dram_cs_n,
    output logic         dram_ras_n,
    output logic         dram_cas_n,
    output logic         dram_we_n
);

io_state_t state;
wait_cnt_t wait_cnt;
ref_cnt_t  ref_cnt;
logic      ref_pending;
logic      ref_issue;
pin_cmd_t  pin_cmd;
logic      dq_oe;
cmd_t      cur_cmd;
logic      rd_issue;

logic [CAS_CYCLES:0] rd_pipe_vld;
tag_t [CAS_CYCLES:0] rd_pipe_tag;

assign dram_clk = CLK;
assign dram_cke = 1'b1;     // no power-down support
assign {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} = pin_cmd;

// write data is only on the bus during the WRITE cycle
assign dram_dq = dq_oe ? cur_cmd.acs.data : 'z;

assign ref_issue = (state == S_IDLE) && ref_pending;
assign cmd_pop   = (state == S_IDLE) && !ref_pending && cmd_valid;
assign rd_issue  = (state == S_ACT) && (wait_cnt == '0) && !cur_cmd.acs.write;

always_ff @(posedge CLK or posedge RESET_IN) begin
    if (RESET_IN) begin
        state     <= S_INIT_WAIT;
        wait_cnt  <= wait_cnt_t'(T_INIT - 1);
        pin_cmd   <= PIN_NOP;
        dram_addr <= '0;
        dram_ba   <= '0;
        dram_dqm  <= 2'b11;     // masked until init is done
        dq_oe     <= 1'b0;
        init_done <= 1'b0;
    end else begin
        pin_cmd <= PIN_NOP;
        dq_oe   <= 1'b0;
        if (wait_cnt != '0)
            wait_cnt <= wait_cnt - 1'b1;

        unique case (state)
            S_INIT_WAIT: if (wait_cnt == '0) begin
                pin_cmd       <= PIN_PRE;
                dram_addr[10] <= 1'b1;      // all banks
                wait_cnt      <= wait_cnt_t'(T_RP - 1);
                state         <= S_INIT_PRE;
            end
            S_INIT_PRE: if (wait_cnt == '0) begin
                pin_cmd  <= PIN_REF;
                wait_cnt <= wait_cnt_t'(T_RC - 1);
                state    <= S_INIT_REF1;
            end
            S_INIT_REF1: if (wait_cnt == '0) begin
                pin_cmd  <= PIN_REF;
                wait_cnt <= wait_cnt_t'(T_RC - 1);
                state    <= S_INIT_REF2;
            end
            S_INIT_REF2: if (wait_cnt == '0) begin
                pin_cmd   <= PIN_MRS;
                dram_addr <= MODE_REG;
                dram_ba   <= '0;
                wait_cnt  <= wait_cnt_t'(T_MRD - 1);
                state     <= S_INIT_MRS;
            end
            S_INIT_MRS: if (wait_cnt == '0) begin
                init_done <= 1'b1;
                dram_dqm  <= 2'b00;
                state     <= S_IDLE;
            end
            S_IDLE: begin
                if (ref_pending) begin
                    pin_cmd  <= PIN_REF;
                    wait_cnt <= wait_cnt_t'(T_RC - 2);  // one more cycle passes in idle
                    state    <= S_REF_WAIT;
                end else if (cmd_valid) begin
                    pin_cmd   <= PIN_ACT;
                    dram_addr <= head_cmd.acs.row;
                    dram_ba   <= head_cmd.acs.bank;
                    wait_cnt  <= wait_cnt_t'(T_RCD - 1);
                    state     <= S_ACT;
                end
            end
            S_ACT: if (wait_cnt == '0) begin
                dram_addr <= {4'b0010, cur_cmd.acs.col};   // a10 set, auto-precharge
                state     <= S_RW_WAIT;
                if (cur_cmd.acs.write) begin
                    pin_cmd  <= PIN_WR;
                    dq_oe    <= 1'b1;
                    wait_cnt <= wait_cnt_t'(T_DPL + T_RP - 1);
                end else begin
                    pin_cmd  <= PIN_RD;
                    wait_cnt <= wait_cnt_t'(T_RC - T_RCD - 2);  // keeps t_rc from activate
                end
            end
            S_RW_WAIT: if (wait_cnt == '0)
                state <= S_IDLE;
            S_REF_WAIT: if (wait_cnt == '0)
                state <= S_IDLE;
            default: state <= S_IDLE;
        endcase
    end
end

always_ff @(posedge CLK) begin
    if (cmd_pop)
        cur_cmd <= head_cmd;
end

// refresh request, served once the current access has finished
always_ff @(posedge CLK or posedge RESET_IN) begin
    if (RESET_IN) begin
        ref_cnt     <= '0;
        ref_pending <= 1'b0;
    end else begin
        if (ref_issue)
            ref_pending <= 1'b0;
        if (init_done) begin
            if (ref_cnt == ref_cnt_t'(T_REF - 1)) begin
                ref_cnt     <= '0;
                ref_pending <= 1'b1;
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
        end
    end
end

// read data shows on dq cas_cycles after the device samples READ
always_ff @(posedge CLK or posedge RESET_IN) begin
    if (RESET_IN) begin
        rd_pipe_vld <= '0;
        rd_valid    <= 1'b0;
    end else begin
        rd_pipe_vld <= {rd_pipe_vld[CAS_CYCLES-1:0], rd_issue};
        rd_valid    <= rd_pipe_vld[CAS_CYCLES];
    end
end

always_ff @(posedge CLK) begin
    rd_pipe_tag <= {rd_pipe_tag[CAS_CYCLES-1:0], cur_cmd.tag};
    if (rd_pipe_vld[CAS_CYCLES]) begin
        rd_data <= dram_dq;
        rd_tag  <= rd_pipe_tag[CAS_CYCLES];
    end
end

endmodule

`default_nettype wire

// ==== source/sdram_cmd_fifo.sv ====
`default_nettype none

module sdram_cmd_fifo import sdram_cmd_pkg::*; (
    input  wire   CLK,
    input  wire   RESET_IN,

    input  logic  cmd_push,
    input  cmd_t  cmd_data,

    input  logic  cmd_pop,
    output logic  cmd_valid,
    output cmd_t  head_cmd,

    output logic  credit_ret
);

cmd_t      mem [CMD_FIFO_DEPTH];
fifo_ptr_t wr_ptr;
fifo_ptr_t rd_ptr;
credit_t   count;
logic      pop;

assign cmd_valid  = (count != '0);
assign head_cmd   = mem[rd_ptr];
assign pop        = cmd_pop && cmd_valid;
assign credit_ret = pop;            // slot is free again

always_ff @(posedge CLK or posedge RESET_IN) begin
    if (RESET_IN) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (cmd_push)
            wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two, wraps by itself
        if (pop)
            rd_ptr <= rd_ptr + 1'b1;
        case ({cmd_push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

// no full check, the arbiter only pushes with a credit in hand
always_ff @(posedge CLK) begin
    if (cmd_push)
        mem[wr_ptr] <= cmd_data;
end

endmodule

`default_nettype wire

// ==== source/sdram_arb.sv ====
`default_nettype none

module sdram_arb import sdram_cmd_pkg::*; (
    input  wire                       CLK,
    input  wire                       RESET_IN,

    input  logic                      init_done,

    // access sources
    input  logic [N_SRC-1:0]          src_req,
    input  dram_access_t [N_SRC-1:0]  src_acs,
    output logic [N_SRC-1:0]          src_ack,

    // command buffer side
    input  logic                      credit_ret,
    output logic                      cmd_push,
    output cmd_t                      cmd_data
);

credit_t          credit;
tag_t             last_grant;
tag_t             grant_idx;
logic             grant_valid;
logic [N_SRC-1:0] eligible;
logic             accept;

// a source whose ack is still showing may not have updated its request yet
assign eligible = src_req & ~src_ack;

assign accept = grant_valid && init_done && (credit != '0);

// round-robin search starting after the last granted source
always_comb begin
    int unsigned idx;

    grant_valid = 1'b0;
    grant_idx   = last_grant;
    for (int i = 1; i <= N_SRC; i++) begin
        idx = (int'(last_grant) + i) % N_SRC;
        if (!grant_valid && eligible[idx]) begin
            grant_valid = 1'b1;
            grant_idx   = tag_t'(idx);
        end
    end
end

always_ff @(posedge CLK or posedge RESET_IN) begin
    if (RESET_IN) begin
        src_ack    <= '0;
        cmd_push   <= 1'b0;
        last_grant <= tag_t'(N_SRC - 1);    // source 0 wins the first round
    end else begin
        src_ack  <= '0;
        cmd_push <= accept;
        if (accept) begin
            src_ack[grant_idx] <= 1'b1;
            last_grant         <= grant_idx;
        end
    end
end

// one credit per free buffer slot
always_ff @(posedge CLK or posedge RESET_IN) begin
    if (RESET_IN) begin
        credit <= credit_t'(CMD_FIFO_DEPTH);
    end else begin
        case ({accept, credit_ret})
            2'b10:   credit <= credit - 1'b1;
            2'b01:   credit <= credit + 1'b1;
            default: credit <= credit;      // none, or one taken and one returned
        endcase
    end
end

always_ff @(posedge CLK) begin
    if (accept) begin
        cmd_data.acs <= src_acs[grant_idx];
        cmd_data.tag <= grant_idx;
    end
end

endmodule

`default_nettype wire

// ==== source/sdram_cmd_pkg.sv ====
`default_nettype none

package sdram_cmd_pkg;

    localparam int N_SRC          = 2;
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int CREDIT_W       = $clog2(CMD_FIFO_DEPTH + 1);

    typedef logic [12:0] row_t;
    typedef logic [1:0]  bank_t;
    typedef logic [8:0]  col_t;
    typedef logic [15:0] data_t;
    typedef logic [0:0]  tag_t;     // index of the issuing source

    typedef logic [CREDIT_W-1:0]               credit_t;
    typedef logic [$clog2(CMD_FIFO_DEPTH)-1:0] fifo_ptr_t;

    typedef struct packed {
        logic  write;
        bank_t bank;
        row_t  row;
        col_t  col;
        data_t data;
    } dram_access_t;

    typedef struct packed {
        dram_access_t acs;
        tag_t         tag;
    } cmd_t;

    // {cs_n, ras_n, cas_n, we_n}
    typedef logic [3:0] pin_cmd_t;

    localparam pin_cmd_t PIN_NOP = 4'b0111;
    localparam pin_cmd_t PIN_ACT = 4'b0011;
    localparam pin_cmd_t PIN_RD  = 4'b0101;
    localparam pin_cmd_t PIN_WR  = 4'b0100;
    localparam pin_cmd_t PIN_PRE = 4'b0010;
    localparam pin_cmd_t PIN_REF = 4'b0001;
    localparam pin_cmd_t PIN_MRS = 4'b0000;

    typedef enum logic [3:0] {
        S_INIT_WAIT,
        S_INIT_PRE,
        S_INIT_REF1,
        S_INIT_REF2,
        S_INIT_MRS,
        S_IDLE,
        S_ACT,
        S_RW_WAIT,
        S_REF_WAIT
    } io_state_t;

endpackage

`default_nettype wire

// ==== source/sdram_timing_pkg.sv ====
`default_nettype none

package sdram_timing_pkg;

    localparam int T_RC   = 9;      // activate to activate, also refresh cycle time
    localparam int T_RCD  = 3;      // activate to read/write
    localparam int T_RP   = 3;      // precharge time
    localparam int T_MRD  = 2;      // mode register set time
    localparam int T_DPL  = 2;      // last write data to precharge
    localparam int T_INIT = 100;    // power-up wait, short for simulation
    localparam int T_REF  = 250;    // refresh interval

    // mode register encoding of the CAS latency
    typedef enum logic [2:0] {
        CAS_2 = 3'd2,
        CAS_3 = 3'd3
    } cas_t;

    localparam cas_t CAS        = CAS_3;
    localparam int   CAS_CYCLES = int'(CAS);

    // burst length 1, sequential, selected cas latency, standard operation
    localparam logic [12:0] MODE_REG = {3'b000, 1'b0, 2'b00, CAS, 1'b0, 3'b000};

    // the power-up delay is normally the longest wait
    localparam int WAIT_MAX = (T_INIT > T_RC) ? T_INIT : T_RC;

    typedef logic [$clog2(WAIT_MAX)-1:0] wait_cnt_t;
    typedef logic [$clog2(T_REF)-1:0]    ref_cnt_t;

endpackage

`default_nettype wire
